//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = dma_engine_tb
FILELIST = dma_engine.f
OBJ_DIR  = obj_dir
PASS_MSG = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/dma_bus_sim.sv
`default_nettype none

module dma_bus_sim (
  input  logic               clk,
  input  logic               rst_n,
  input  int                 fixed_delay,
  input  logic               bus_req,
  output logic               bus_grant,
  input  dma_bus_pkg::addr_t bus_addr,
  input  dma_bus_pkg::data_t bus_wdata,
  output dma_bus_pkg::data_t bus_rdata,
  input  logic               bus_mem,
  input  logic               bus_io,
  input  logic               bus_rd,
  input  logic               bus_wr
);
  timeunit 1ns;
  timeprecision 1ps;

  dma_bus_pkg::data_t mem [256];
  dma_bus_pkg::data_t io_mem [256];
  dma_bus_pkg::data_t io_seq;
  int                 wait_cnt;
  int                 cycle;
  // strobe log, one entry per read or write cycle
  dma_bus_pkg::addr_t rd_addr_q [$];
  logic               rd_io_q [$];
  int                 rd_cycle_q [$];
  dma_bus_pkg::addr_t wr_addr_q [$];
  dma_bus_pkg::data_t wr_data_q [$];
  logic               wr_io_q [$];

  // I/O reads return a running sequence, memory is indexed by the low address byte
  assign bus_rdata = bus_io ? io_seq : mem[bus_addr[7:0]];

  initial bus_grant = 1'b0;

  // grant follows a request after one to three cycles and is held while requested
  always @(negedge clk) begin
    if (!rst_n || !bus_req) begin
      bus_grant <= 1'b0;
      wait_cnt  <= (fixed_delay > 0) ? fixed_delay : int'($urandom_range(3, 1));
    end else if (!bus_grant) begin
      if (wait_cnt <= 1) begin
        bus_grant <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!rst_n) begin
      io_seq <= 8'h40;
      for (int i = 0; i < 256; i++) begin
        mem[i] <= 8'(i * 29) ^ 8'(i >> 3) ^ 8'ha5;
      end
    end else begin
      if (bus_rd) begin
        rd_addr_q.push_back(bus_addr);
        rd_io_q.push_back(bus_io);
        rd_cycle_q.push_back(cycle);
        if (bus_io) begin
          io_seq <= io_seq + 1'b1;
        end
      end
      if (bus_wr) begin
        wr_addr_q.push_back(bus_addr);
        wr_data_q.push_back(bus_wdata);
        wr_io_q.push_back(bus_io);
        if (bus_io) begin
          io_mem[bus_addr[7:0]] <= bus_wdata;
        end else if (bus_mem) begin
          mem[bus_addr[7:0]] <= bus_wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/dma_engine_tb.sv
`default_nettype none

module dma_engine_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_RUNS   = 16;
  localparam int MAX_LEN    = 16;
  localparam int MAX_PRE    = 12;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * 4 * MAX_LEN * (MAX_PRE + 5) + 20000;

  logic clk;
  logic rst_n;
  logic psel;
  logic penable;
  logic pwrite;
  int   fixed_delay;
  logic bus_req;
  logic bus_grant;
  logic bus_mem;
  logic bus_io;
  logic bus_rd;
  logic bus_wr;
  dma_bus_pkg::addr_t     paddr;
  dma_reg_pkg::reg_data_t pwdata;
  dma_reg_pkg::reg_data_t prdata;
  dma_bus_pkg::addr_t     bus_addr;
  dma_bus_pkg::data_t     bus_wdata;
  dma_bus_pkg::data_t     bus_rdata;
  // reference model state
  dma_bus_pkg::data_t     shadow [256];
  dma_bus_pkg::data_t     io_seq_model;

  dma_engine dma_engine_i (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .bus_req, .bus_grant, .bus_addr, .bus_wdata, .bus_rdata,
    .bus_mem, .bus_io, .bus_rd, .bus_wr
  );

  dma_bus_sim bus_sim_i (
    .clk, .rst_n, .fixed_delay, .bus_req, .bus_grant, .bus_addr, .bus_wdata,
    .bus_rdata, .bus_mem, .bus_io, .bus_rd, .bus_wr
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_reg(input string name, input dma_reg_pkg::reg_data_t got,
                           input dma_reg_pkg::reg_data_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_data(input string name, input dma_bus_pkg::data_t got,
                            input dma_bus_pkg::data_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(input string name, input dma_bus_pkg::addr_t got,
                            input dma_bus_pkg::addr_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // strobes need the grant and exactly one of memory or I/O space
  always @(posedge clk) begin
    if (rst_n && (bus_rd || bus_wr)) begin
      if (!bus_grant || (bus_mem == bus_io)) begin
        $display("bus strobe at %0t without grant or with a bad space select", $time);
        stop_with_failure();
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD * 1ns);
    $display("timeout, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  task automatic apb_write(input dma_reg_pkg::reg_addr_t idx,
                           input dma_reg_pkg::reg_data_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = {12'h000, idx, 1'b0};
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input dma_reg_pkg::reg_addr_t idx,
                          output dma_reg_pkg::reg_data_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = {12'h000, idx, 1'b0};
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic dma_reg_pkg::reg_data_t ctrl_value(input dma_reg_pkg::mode_e mode,
      input logic src_io, input logic dst_io, input logic probe_dst);
    dma_reg_pkg::reg_data_t w;
    w = '0;
    w[dma_reg_pkg::CTRL_MODE_MSB:dma_reg_pkg::CTRL_MODE_LSB] = mode;
    w[dma_reg_pkg::CTRL_DST_IO]    = dst_io;
    w[dma_reg_pkg::CTRL_SRC_IO]    = src_io;
    w[dma_reg_pkg::CTRL_PROBE_DST] = probe_dst;
    return w;
  endfunction

  task automatic wait_mode_off();
    dma_reg_pkg::reg_data_t rdata;
    int polls;
    polls = 0;
    apb_read(dma_reg_pkg::REG_CTRL, rdata);
    while (rdata[dma_reg_pkg::CTRL_MODE_MSB:dma_reg_pkg::CTRL_MODE_LSB] != 2'b00) begin
      polls++;
      if (polls > 5000) begin
        $display("the transfer never turned its mode off");
        stop_with_failure();
      end
      apb_read(dma_reg_pkg::REG_CTRL, rdata);
    end
  endtask

  task automatic wait_not_busy();
    dma_reg_pkg::reg_data_t rdata;
    int polls;
    polls = 0;
    apb_read(dma_reg_pkg::REG_STAT, rdata);
    while (rdata[dma_reg_pkg::STAT_BUSY]) begin
      polls++;
      if (polls > 5000) begin
        $display("the sequencer stayed busy after the mode was written off");
        stop_with_failure();
      end
      apb_read(dma_reg_pkg::REG_STAT, rdata);
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < 256; i++) begin
      check_data($sformatf("mem[%0d]", i), bus_sim_i.mem[i], shadow[i]);
    end
  endtask

  // program one copy, wait for it and compare every strobe with the model
  task automatic run_copy(input dma_reg_pkg::mode_e mode, input logic src_io,
      input logic dst_io, input logic probe_dst, input dma_bus_pkg::addr_t src,
      input dma_bus_pkg::addr_t dst, input dma_bus_pkg::count_t len,
      input dma_bus_pkg::count_t pre, output dma_reg_pkg::reg_data_t stat);
    int rd_base;
    int wr_base;
    int gap;
    dma_bus_pkg::addr_t exp_addr;
    dma_bus_pkg::data_t exp_data;
    rd_base = bus_sim_i.rd_addr_q.size();
    wr_base = bus_sim_i.wr_addr_q.size();
    apb_write(dma_reg_pkg::REG_SRC, src);
    apb_write(dma_reg_pkg::REG_DST, dst);
    apb_write(dma_reg_pkg::REG_PRE, pre);
    apb_write(dma_reg_pkg::REG_LEN, len);
    apb_write(dma_reg_pkg::REG_CTRL, ctrl_value(mode, src_io, dst_io, probe_dst));
    wait_mode_off();
    check_reg("read strobe count", 16'(bus_sim_i.rd_addr_q.size() - rd_base), len);
    check_reg("write strobe count", 16'(bus_sim_i.wr_addr_q.size() - wr_base), len);
    for (int i = 0; i < int'(len); i++) begin
      exp_addr = src_io ? src : src + 16'(i);
      check_addr("bus_addr on read", bus_sim_i.rd_addr_q[rd_base + i], exp_addr);
      check_reg("bus_io on read", 16'(bus_sim_i.rd_io_q[rd_base + i]), 16'(src_io));
      if (src_io) begin
        exp_data = io_seq_model;
        io_seq_model++;
      end else begin
        exp_data = shadow[exp_addr[7:0]];
      end
      exp_addr = dst_io ? dst : dst + 16'(i);
      check_addr("bus_addr on write", bus_sim_i.wr_addr_q[wr_base + i], exp_addr);
      check_reg("bus_io on write", 16'(bus_sim_i.wr_io_q[wr_base + i]), 16'(dst_io));
      check_data("bus_wdata", bus_sim_i.wr_data_q[wr_base + i], exp_data);
      if (!dst_io) begin
        shadow[exp_addr[7:0]] = exp_data;
      end
      if (i > 0 && mode == dma_reg_pkg::MODE_TIMED) begin
        gap = bus_sim_i.rd_cycle_q[rd_base + i] - bus_sim_i.rd_cycle_q[rd_base + i - 1];
        if (gap < int'(pre) + 1) begin
          $display("timed read strobes only %0d cycles apart with prescale %0d", gap, pre);
          stop_with_failure();
        end
      end
    end
    // the I/O port keeps the last byte written to it
    if (dst_io && len != 0) begin
      check_data("I/O port data", bus_sim_i.io_mem[dst[7:0]], exp_data);
    end
    apb_read(dma_reg_pkg::REG_STAT, stat);
    check_reg("status busy", stat & 16'h0002, 16'h0000);
    check_memory();
  endtask

  task automatic run_repeat(input dma_bus_pkg::addr_t src, input dma_bus_pkg::addr_t dst,
                            input dma_bus_pkg::count_t len, input dma_bus_pkg::count_t pre);
    int rd_base;
    int wr_base;
    int waited;
    int n;
    dma_bus_pkg::addr_t s_addr;
    rd_base = bus_sim_i.rd_addr_q.size();
    wr_base = bus_sim_i.wr_addr_q.size();
    apb_write(dma_reg_pkg::REG_SRC, src);
    apb_write(dma_reg_pkg::REG_DST, dst);
    apb_write(dma_reg_pkg::REG_PRE, pre);
    apb_write(dma_reg_pkg::REG_LEN, len);
    apb_write(dma_reg_pkg::REG_CTRL, ctrl_value(dma_reg_pkg::MODE_TIMED_REPEAT, 0, 0, 0));
    waited = 0;
    while (bus_sim_i.rd_addr_q.size() - rd_base < 2 * int'(len) + 1) begin
      @(negedge clk);
      waited++;
      if (waited > 20000) begin
        $display("timed-repeat stopped copying before its second pass");
        stop_with_failure();
      end
    end
    apb_write(dma_reg_pkg::REG_CTRL, 16'h0000);
    wait_not_busy();
    n = bus_sim_i.wr_addr_q.size() - wr_base;
    check_reg("repeat write count", 16'(n), 16'(bus_sim_i.rd_addr_q.size() - rd_base));
    for (int k = 0; k < n; k++) begin
      s_addr = src + 16'(k % int'(len));
      check_addr("bus_addr on repeat read", bus_sim_i.rd_addr_q[rd_base + k], s_addr);
      check_addr("bus_addr on repeat write", bus_sim_i.wr_addr_q[wr_base + k],
                 dst + 16'(k % int'(len)));
      check_data("bus_wdata on repeat", bus_sim_i.wr_data_q[wr_base + k], shadow[s_addr[7:0]]);
    end
    for (int j = 0; j < int'(len); j++) begin
      s_addr = dst + 16'(j);
      shadow[s_addr[7:0]] = shadow[8'(src) + 8'(j)];
    end
    check_memory();
  endtask

  function automatic dma_bus_pkg::addr_t low_block();
    return {8'($urandom), 2'b00, 6'($urandom)};
  endfunction

  function automatic dma_bus_pkg::addr_t high_block();
    return {8'($urandom), 2'b10, 6'($urandom)};
  endfunction

  initial begin
    int unused_seed;
    dma_reg_pkg::reg_data_t rdata;
    dma_reg_pkg::reg_data_t wval;
    dma_bus_pkg::addr_t src;
    dma_bus_pkg::addr_t dst;
    dma_bus_pkg::count_t len;
    unused_seed = $urandom(13);
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    fixed_delay = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = bus_sim_i.mem[i];
    end
    io_seq_model = 8'h40;

    // reset values
    for (int r = 0; r < 8; r++) begin
      apb_read(3'(r), rdata);
      check_reg($sformatf("register %0d after reset", r), rdata, 16'h0000);
    end
    check_reg("bus_req", 16'(bus_req), 16'h0000);
    check_reg("bus_rd", 16'(bus_rd), 16'h0000);
    check_reg("bus_wr", 16'(bus_wr), 16'h0000);

    // register read back, mode kept off so nothing starts
    for (int r = 2; r < 7; r++) begin
      wval = 16'($urandom);
      apb_write(3'(r), wval);
      apb_read(3'(r), rdata);
      check_reg($sformatf("register %0d read back", r), rdata, wval);
    end
    wval = 16'($urandom) & 16'hfffc;
    apb_write(dma_reg_pkg::REG_CTRL, wval);
    apb_read(dma_reg_pkg::REG_CTRL, rdata);
    check_reg("control read back", rdata, wval & 16'h001f);
    apb_write(dma_reg_pkg::REG_CTRL, 16'h0000);

    // memory to memory bursts, the last one of length zero
    for (int t = 0; t < 4; t++) begin
      len = 16'($urandom_range(MAX_LEN, 1));
      run_copy(dma_reg_pkg::MODE_BURST, 0, 0, 0, low_block(), high_block(), len, 0, rdata);
    end
    run_copy(dma_reg_pkg::MODE_BURST, 0, 0, 0, low_block(), high_block(), 0, 0, rdata);

    // I/O to memory and memory to I/O
    len = 16'($urandom_range(MAX_LEN, 1));
    run_copy(dma_reg_pkg::MODE_BURST, 1, 0, 0, 16'($urandom), high_block(), len, 0, rdata);
    len = 16'($urandom_range(MAX_LEN, 1));
    run_copy(dma_reg_pkg::MODE_BURST, 0, 1, 0, low_block(), 16'($urandom), len, 0, rdata);

    // timed modes with a steady grant delay so strobe spacing follows the prescaler
    fixed_delay = 2;
    for (int t = 0; t < 2; t++) begin
      len = 16'($urandom_range(8, 1));
      run_copy(dma_reg_pkg::MODE_TIMED, 0, 0, 0, low_block(), high_block(), len,
               16'($urandom_range(MAX_PRE, 4)), rdata);
    end
    run_repeat(low_block(), high_block(), 16'($urandom_range(4, 2)), 16'd3);
    fixed_delay = 0;

    // probe on the source, a probe that is never reached, and one on the destination
    apb_read(dma_reg_pkg::REG_STAT, rdata);
    src = low_block();
    dst = high_block();
    len = 16'($urandom_range(MAX_LEN, 2));
    apb_write(dma_reg_pkg::REG_PROBE, src + 16'($urandom_range(int'(len) - 1, 0)));
    run_copy(dma_reg_pkg::MODE_BURST, 0, 0, 0, src, dst, len, 0, rdata);
    check_reg("status after source probe", rdata, 16'h0001);
    apb_read(dma_reg_pkg::REG_STAT, rdata);
    check_reg("status on second read", rdata, 16'h0000);
    apb_write(dma_reg_pkg::REG_PROBE, src + len + 16'd3);
    run_copy(dma_reg_pkg::MODE_BURST, 0, 0, 0, src, dst, len, 0, rdata);
    check_reg("status with probe not reached", rdata, 16'h0000);
    apb_write(dma_reg_pkg::REG_PROBE, dst + len - 16'd1);
    run_copy(dma_reg_pkg::MODE_BURST, 0, 0, 1, src, dst, len, 0, rdata);
    check_reg("status after destination probe", rdata, 16'h0001);
    apb_read(dma_reg_pkg::REG_STAT, rdata);
    check_reg("status on second read", rdata, 16'h0000);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dma_engine.f
src/dma_reg_pkg.sv
src/dma_bus_pkg.sv
src/dma_regs.sv
src/dma_pacer.sv
src/dma_datapath.sv
src/dma_sequencer.sv
src/dma_engine.sv
bench/dma_bus_sim.sv
bench/dma_engine_tb.sv

//--- src/dma_bus_pkg.sv
`default_nettype none

package dma_bus_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  // shared by the transfer counter and the prescaler
  typedef logic [15:0] count_t;

  // the grant states start a byte, the next three states move it
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,
    ST_BURST_GRANT = 3'd1,
    ST_TIMED_WAIT  = 3'd2,
    ST_TIMED_GRANT = 3'd3,
    ST_READ        = 3'd4,
    ST_WRITE       = 3'd5,
    ST_FINISH      = 3'd6
  } seq_state_e;

endpackage

`default_nettype wire

//--- src/dma_datapath.sv
`default_nettype none

module dma_datapath (
  input  logic               clk,
  input  logic               rst_n,
  input  dma_bus_pkg::addr_t src_base,
  input  dma_bus_pkg::addr_t dst_base,
  input  dma_bus_pkg::addr_t probe_addr,
  input  logic               src_io,
  input  logic               dst_io,
  input  logic               probe_dst,
  input  logic               load_base,
  input  logic               capture_data,
  input  logic               advance,
  input  logic               addr_is_dst,
  input  dma_bus_pkg::data_t bus_rdata,
  output dma_bus_pkg::addr_t bus_addr,
  output dma_bus_pkg::data_t bus_wdata,
  output logic               probe_hit
);

  dma_bus_pkg::addr_t src_idx;
  dma_bus_pkg::addr_t dst_idx;
  dma_bus_pkg::addr_t watched_idx;

  // I/O ports keep a fixed address, memory walks upward
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_idx <= '0;
      dst_idx <= '0;
    end else if (load_base) begin
      src_idx <= src_base;
      dst_idx <= dst_base;
    end else if (advance) begin
      if (!src_io) begin
        src_idx <= src_idx + 1'b1;
      end
      if (!dst_io) begin
        dst_idx <= dst_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus_addr <= '0;
    end else begin
      bus_addr <= addr_is_dst ? dst_idx : src_idx;
    end
  end

  // the byte read is held on the write data lines until the next read
  always_ff @(posedge clk) begin
    if (capture_data) begin
      bus_wdata <= bus_rdata;
    end
  end

  // compared while the byte is captured, both indexes are still those of this byte
  assign watched_idx = probe_dst ? dst_idx : src_idx;
  assign probe_hit   = capture_data && (watched_idx == probe_addr);

endmodule

`default_nettype wire

//--- src/dma_engine.sv
`default_nettype none

module dma_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  dma_bus_pkg::addr_t     paddr,
  input  dma_reg_pkg::reg_data_t pwdata,
  output dma_reg_pkg::reg_data_t prdata,
  output logic                   bus_req,
  input  logic                   bus_grant,
  output dma_bus_pkg::addr_t     bus_addr,
  output dma_bus_pkg::data_t     bus_wdata,
  input  dma_bus_pkg::data_t     bus_rdata,
  output logic                   bus_mem,
  output logic                   bus_io,
  output logic                   bus_rd,
  output logic                   bus_wr
);

  dma_reg_pkg::mode_e  mode;
  logic                src_io;
  logic                dst_io;
  logic                probe_dst;
  dma_bus_pkg::addr_t  src_base;
  dma_bus_pkg::addr_t  dst_base;
  dma_bus_pkg::addr_t  probe_addr;
  dma_bus_pkg::count_t prescale;
  dma_bus_pkg::count_t length;
  logic                mode_clear;
  logic                probe_hit;
  logic                busy;
  logic                tick;
  logic                count_zero;
  logic                load_base;
  logic                load_count;
  logic                dec_count;
  logic                pacer_restart;
  logic                capture_data;
  logic                advance;
  logic                addr_is_dst;

  dma_regs dma_regs_i (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .mode_clear, .probe_hit, .busy,
    .mode, .src_io, .dst_io, .probe_dst,
    .src_base, .dst_base, .probe_addr, .prescale, .length
  );

  dma_pacer dma_pacer_i (
    .clk, .rst_n, .prescale, .length,
    .pacer_restart, .load_count, .dec_count, .tick, .count_zero
  );

  dma_datapath dma_datapath_i (
    .clk, .rst_n, .src_base, .dst_base, .probe_addr,
    .src_io, .dst_io, .probe_dst,
    .load_base, .capture_data, .advance, .addr_is_dst,
    .bus_rdata, .bus_addr, .bus_wdata, .probe_hit
  );

  dma_sequencer dma_sequencer_i (
    .clk, .rst_n, .mode, .src_io, .dst_io, .tick, .count_zero, .bus_grant,
    .bus_req, .bus_mem, .bus_io, .bus_rd, .bus_wr,
    .load_base, .load_count, .dec_count, .pacer_restart,
    .capture_data, .advance, .addr_is_dst, .mode_clear, .busy
  );

endmodule

`default_nettype wire

//--- src/dma_pacer.sv
`default_nettype none

module dma_pacer (
  input  logic                clk,
  input  logic                rst_n,
  input  dma_bus_pkg::count_t prescale,
  input  dma_bus_pkg::count_t length,
  input  logic                pacer_restart,
  input  logic                load_count,
  input  logic                dec_count,
  output logic                tick,
  output logic                count_zero
);

  dma_bus_pkg::count_t pre_cnt;
  dma_bus_pkg::count_t xfer_cnt;

  // the prescaler spends one cycle at zero, so its period is prescale+1
  assign tick       = (pre_cnt == '0);
  assign count_zero = (xfer_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pre_cnt <= '0;
    end else if (pacer_restart || tick) begin
      pre_cnt <= prescale;
    end else begin
      pre_cnt <= pre_cnt - 1'b1;
    end
  end

  // bytes still to move in the current pass
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xfer_cnt <= '0;
    end else if (load_count) begin
      xfer_cnt <= length;
    end else if (dec_count) begin
      xfer_cnt <= xfer_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/dma_reg_pkg.sv
`default_nettype none

package dma_reg_pkg;

  // register index, taken from paddr bits 3 to 1
  typedef logic [2:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  localparam reg_addr_t REG_CTRL  = 3'd0;
  localparam reg_addr_t REG_STAT  = 3'd1;
  localparam reg_addr_t REG_SRC   = 3'd2;
  localparam reg_addr_t REG_DST   = 3'd3;
  localparam reg_addr_t REG_PRE   = 3'd4;
  localparam reg_addr_t REG_LEN   = 3'd5;
  localparam reg_addr_t REG_PROBE = 3'd6;

  typedef enum logic [1:0] {
    MODE_OFF          = 2'd0,
    MODE_BURST        = 2'd1,
    MODE_TIMED        = 2'd2,
    MODE_TIMED_REPEAT = 2'd3
  } mode_e;

  // control word fields
  localparam int CTRL_MODE_LSB  = 0;
  localparam int CTRL_MODE_MSB  = 1;
  localparam int CTRL_DST_IO    = 2;
  localparam int CTRL_SRC_IO    = 3;
  localparam int CTRL_PROBE_DST = 4;

  // status word fields
  localparam int STAT_PROBE = 0;
  localparam int STAT_BUSY  = 1;

endpackage

`default_nettype wire

//--- src/dma_regs.sv
`default_nettype none

module dma_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  dma_bus_pkg::addr_t     paddr,
  input  dma_reg_pkg::reg_data_t pwdata,
  output dma_reg_pkg::reg_data_t prdata,
  input  logic                   mode_clear,
  input  logic                   probe_hit,
  input  logic                   busy,
  output dma_reg_pkg::mode_e     mode,
  output logic                   src_io,
  output logic                   dst_io,
  output logic                   probe_dst,
  output dma_bus_pkg::addr_t     src_base,
  output dma_bus_pkg::addr_t     dst_base,
  output dma_bus_pkg::addr_t     probe_addr,
  output dma_bus_pkg::count_t    prescale,
  output dma_bus_pkg::count_t    length
);

  dma_reg_pkg::reg_addr_t reg_idx;
  dma_reg_pkg::reg_data_t ctrl_word;
  dma_reg_pkg::reg_data_t stat_word;
  logic                   wr_access;
  logic                   ctrl_write;
  logic                   stat_read;
  logic                   probe_flag;

  // registers sit on 16-bit word boundaries
  assign reg_idx    = paddr[3:1];
  assign wr_access  = psel && penable && pwrite;
  assign ctrl_write = wr_access && (reg_idx == dma_reg_pkg::REG_CTRL);
  assign stat_read  = psel && penable && !pwrite && (reg_idx == dma_reg_pkg::REG_STAT);

  always_comb begin
    ctrl_word = '0;
    ctrl_word[dma_reg_pkg::CTRL_MODE_MSB:dma_reg_pkg::CTRL_MODE_LSB] = mode;
    ctrl_word[dma_reg_pkg::CTRL_DST_IO]    = dst_io;
    ctrl_word[dma_reg_pkg::CTRL_SRC_IO]    = src_io;
    ctrl_word[dma_reg_pkg::CTRL_PROBE_DST] = probe_dst;
    stat_word = '0;
    stat_word[dma_reg_pkg::STAT_PROBE] = probe_flag;
    stat_word[dma_reg_pkg::STAT_BUSY]  = busy;
  end

  // read data is valid in setup and access phase alike
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (reg_idx)
        dma_reg_pkg::REG_CTRL:  prdata = ctrl_word;
        dma_reg_pkg::REG_STAT:  prdata = stat_word;
        dma_reg_pkg::REG_SRC:   prdata = src_base;
        dma_reg_pkg::REG_DST:   prdata = dst_base;
        dma_reg_pkg::REG_PRE:   prdata = prescale;
        dma_reg_pkg::REG_LEN:   prdata = length;
        dma_reg_pkg::REG_PROBE: prdata = probe_addr;
        default:                prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode       <= dma_reg_pkg::MODE_OFF;
      src_io     <= 1'b0;
      dst_io     <= 1'b0;
      probe_dst  <= 1'b0;
      src_base   <= '0;
      dst_base   <= '0;
      prescale   <= '0;
      length     <= '0;
      probe_addr <= '0;
      probe_flag <= 1'b0;
    end else begin
      if (wr_access) begin
        case (reg_idx)
          dma_reg_pkg::REG_CTRL: begin
            mode <= dma_reg_pkg::mode_e'(
              pwdata[dma_reg_pkg::CTRL_MODE_MSB:dma_reg_pkg::CTRL_MODE_LSB]);
            dst_io    <= pwdata[dma_reg_pkg::CTRL_DST_IO];
            src_io    <= pwdata[dma_reg_pkg::CTRL_SRC_IO];
            probe_dst <= pwdata[dma_reg_pkg::CTRL_PROBE_DST];
          end
          dma_reg_pkg::REG_SRC:   src_base   <= pwdata;
          dma_reg_pkg::REG_DST:   dst_base   <= pwdata;
          dma_reg_pkg::REG_PRE:   prescale   <= pwdata;
          dma_reg_pkg::REG_LEN:   length     <= pwdata;
          dma_reg_pkg::REG_PROBE: probe_addr <= pwdata;
          default: ;
        endcase
      end
      // a CPU write to control wins over the sequencer turning itself off
      if (mode_clear && !ctrl_write) begin
        mode <= dma_reg_pkg::MODE_OFF;
      end
      // a hit in the same cycle as the status read is kept for the next read
      if (probe_hit) begin
        probe_flag <= 1'b1;
      end else if (stat_read) begin
        probe_flag <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dma_sequencer.sv
`default_nettype none

module dma_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  dma_reg_pkg::mode_e mode,
  input  logic               src_io,
  input  logic               dst_io,
  input  logic               tick,
  input  logic               count_zero,
  input  logic               bus_grant,
  output logic               bus_req,
  output logic               bus_mem,
  output logic               bus_io,
  output logic               bus_rd,
  output logic               bus_wr,
  output logic               load_base,
  output logic               load_count,
  output logic               dec_count,
  output logic               pacer_restart,
  output logic               capture_data,
  output logic               advance,
  output logic               addr_is_dst,
  output logic               mode_clear,
  output logic               busy
);

  dma_bus_pkg::seq_state_e state;
  dma_bus_pkg::seq_state_e ret_state;
  logic                    timed_mode;
  logic                    start_byte;

  assign timed_mode = (mode == dma_reg_pkg::MODE_TIMED) ||
                      (mode == dma_reg_pkg::MODE_TIMED_REPEAT);
  assign busy       = (state != dma_bus_pkg::ST_IDLE);

  // a grant with bytes left starts the read cycle
  assign start_byte = bus_grant && !count_zero &&
                      ((state == dma_bus_pkg::ST_BURST_GRANT) ||
                       (state == dma_bus_pkg::ST_TIMED_GRANT));

  // the source address goes out from the grant states, the destination after the read
  assign addr_is_dst = (state == dma_bus_pkg::ST_READ) ||
                       (state == dma_bus_pkg::ST_WRITE) ||
                       (state == dma_bus_pkg::ST_FINISH);
  assign capture_data = (state == dma_bus_pkg::ST_READ);
  assign dec_count    = (state == dma_bus_pkg::ST_FINISH);
  assign advance      = (state == dma_bus_pkg::ST_FINISH);

  always_comb begin
    load_base     = 1'b0;
    load_count    = 1'b0;
    pacer_restart = 1'b0;
    mode_clear    = 1'b0;
    case (state)
      dma_bus_pkg::ST_IDLE: begin
        load_base     = (mode != dma_reg_pkg::MODE_OFF);
        load_count    = (mode != dma_reg_pkg::MODE_OFF);
        pacer_restart = timed_mode;
      end
      dma_bus_pkg::ST_BURST_GRANT: begin
        mode_clear = bus_grant && count_zero;
      end
      dma_bus_pkg::ST_TIMED_GRANT: begin
        // timed-repeat starts a new pass instead of finishing
        if (bus_grant && count_zero) begin
          if (mode == dma_reg_pkg::MODE_TIMED_REPEAT) begin
            load_base  = 1'b1;
            load_count = 1'b1;
          end else begin
            mode_clear = 1'b1;
          end
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= dma_bus_pkg::ST_IDLE;
      ret_state <= dma_bus_pkg::ST_IDLE;
      bus_req   <= 1'b0;
      bus_mem   <= 1'b0;
      bus_io    <= 1'b0;
      bus_rd    <= 1'b0;
      bus_wr    <= 1'b0;
    end else begin
      case (state)
        dma_bus_pkg::ST_IDLE: begin
          // the request from a finished burst is released here
          bus_req <= (mode == dma_reg_pkg::MODE_BURST);
          if (mode == dma_reg_pkg::MODE_BURST) begin
            state <= dma_bus_pkg::ST_BURST_GRANT;
          end else if (timed_mode) begin
            state <= dma_bus_pkg::ST_TIMED_WAIT;
          end
        end
        dma_bus_pkg::ST_BURST_GRANT, dma_bus_pkg::ST_TIMED_GRANT: begin
          if (start_byte) begin
            bus_rd    <= 1'b1;
            bus_mem   <= !src_io;
            bus_io    <= src_io;
            ret_state <= (state == dma_bus_pkg::ST_BURST_GRANT) ?
                         dma_bus_pkg::ST_BURST_GRANT : dma_bus_pkg::ST_TIMED_WAIT;
            state     <= dma_bus_pkg::ST_READ;
          end else if (mode_clear) begin
            state <= dma_bus_pkg::ST_IDLE;
          end
        end
        dma_bus_pkg::ST_TIMED_WAIT: begin
          if (mode == dma_reg_pkg::MODE_OFF) begin
            bus_req <= 1'b0;
            state   <= dma_bus_pkg::ST_IDLE;
          end else if (tick) begin
            bus_req <= 1'b1;
            state   <= dma_bus_pkg::ST_TIMED_GRANT;
          end
        end
        dma_bus_pkg::ST_READ: begin
          bus_rd  <= 1'b0;
          bus_mem <= 1'b0;
          bus_io  <= 1'b0;
          state   <= dma_bus_pkg::ST_WRITE;
        end
        dma_bus_pkg::ST_WRITE: begin
          bus_wr  <= 1'b1;
          bus_mem <= !dst_io;
          bus_io  <= dst_io;
          state   <= dma_bus_pkg::ST_FINISH;
        end
        dma_bus_pkg::ST_FINISH: begin
          bus_wr  <= 1'b0;
          bus_mem <= 1'b0;
          bus_io  <= 1'b0;
          // timed modes give the bus back between bytes
          bus_req <= (ret_state == dma_bus_pkg::ST_BURST_GRANT);
          state   <= ret_state;
        end
        default: state <= dma_bus_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire
